/* hdl/sfi_crd_pkg.sv */
// fabric rx credit definitions
package sfi_crd_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int NUM_VCS   = 2;                 // local virtual channels
  localparam int VC_W      = 1;
  localparam int NUM_FC    = 3;                 // P, NP, CPL
  localparam int NUM_FLOWS = NUM_VCS * NUM_FC;  // flow = vc*3 + fc
  localparam int FLOW_W    = 3;
  localparam int CNT_W     = 8;                 // credit counter width
  localparam int RTN_W     = 4;                 // return value field
  localparam int LINK_VC_W = 3;                 // link side vc id
  localparam int VC_MAP_W  = 4;                 // map field per local vc

  localparam int CHAN_HDR  = 0;
  localparam int CHAN_DATA = 1;

  // --------------------
  // credit tables, indexed [chan][vc][fc]
  // --------------------
  localparam int unsigned RTN_MAX [2] = '{15, 7};  // largest single return

  // an infinite flow loads 1 so the arbiter sees it once
  localparam int unsigned INIT_CRD [2][NUM_VCS][NUM_FC] = '{
    '{'{20, 2, 1}, '{3, 0, 0}},   // header
    '{'{ 9, 1, 1}, '{0, 0, 0}}    // data
  };

  localparam bit INF_CRD [2][NUM_VCS][NUM_FC] = '{
    '{'{1'b0, 1'b0, 1'b1}, '{1'b0, 1'b0, 1'b0}},
    '{'{1'b0, 1'b0, 1'b1}, '{1'b0, 1'b0, 1'b0}}
  };

  typedef enum logic [1:0] {
    FC_P   = 2'd0,   // posted
    FC_NP  = 2'd1,   // non-posted
    FC_CPL = 2'd2    // completion
  } fc_id_t;

  // locally freed credits, one cycle strobe
  typedef struct packed {
    logic             valid;
    logic [VC_W-1:0]  vc;
    fc_id_t           fc;
    logic [RTN_W-1:0] value;
  } crd_free_t;

  // credit return towards the link
  typedef struct packed {
    logic                 valid;
    logic [LINK_VC_W-1:0] vc_id;
    fc_id_t               fc;
    logic [RTN_W-1:0]     value;
  } crd_rtn_t;

endpackage

/* hdl/crd_link_ctrl.sv */
// credit link control
`timescale 1ns/1ps

module crd_link_ctrl (
  input  logic clk_gated,
  input  logic rst_b,
  input  logic connected,     // rx link connected
  input  logic disconnected,  // rx link disconnected
  input  logic force_blocks,  // quiesce request
  input  logic go_idle_ack,
  input  logic hdr_block,     // partner blocks header returns
  input  logic data_block,    // partner blocks data returns
  input  logic hdr_empty,
  input  logic data_empty,
  output logic load,
  output logic count_en,
  output logic hdr_hold,
  output logic data_hold,
  output logic crd_idle
);

  logic init_reqd_q;  // counters need the initial credits
  logic quiesce;

  // --------------------
  // init sequencing
  // --------------------
  always_ff @(posedge clk_gated or negedge rst_b) begin
    if (!rst_b) begin
      init_reqd_q <= 1'b1;
    end else if (connected && init_reqd_q) begin
      init_reqd_q <= 1'b0;  // load happens on this edge
    end else if (disconnected) begin
      init_reqd_q <= 1'b1;
    end
  end

  assign load     = connected & init_reqd_q;   // one cycle per connect
  assign count_en = connected & ~init_reqd_q;

  // no returns while blocked, quiescing or after go-idle ack
  assign quiesce   = force_blocks | go_idle_ack;
  assign hdr_hold  = hdr_block | quiesce;
  assign data_hold = data_block | quiesce;

  assign crd_idle = ~init_reqd_q & hdr_empty & data_empty;

  // link state machine is one-hot between these two
  a_conn_excl : assert property (@(posedge clk_gated) disable iff (!rst_b)
    !(connected && disconnected));

endmodule

/* hdl/crd_rtn_counters.sv */
// credit return counter bank
`timescale 1ns/1ps

module crd_rtn_counters #(
  parameter int CHAN = sfi_crd_pkg::CHAN_HDR
) (
  input  logic                                        clk_gated,
  input  logic                                        rst_b,
  input  logic                                        load,      // take initial credits
  input  logic                                        count_en,  // normal running
  input  sfi_crd_pkg::crd_free_t                      free,
  input  logic [sfi_crd_pkg::FLOW_W-1:0]              dec_flow,  // flow being returned
  input  logic [sfi_crd_pkg::RTN_W-1:0]               dec_val,   // zero when no return
  output logic [sfi_crd_pkg::NUM_FLOWS-1:0]           reqs,
  output logic [sfi_crd_pkg::NUM_FLOWS-1:0][sfi_crd_pkg::CNT_W-1:0] cnts
);

  import sfi_crd_pkg::*;

  logic [NUM_FLOWS-1:0][CNT_W-1:0] cnt_q;

  // --------------------
  // one counter per vc/fc
  // --------------------
  for (genvar gv = 0; gv < NUM_VCS; gv++) begin : g_vc
    for (genvar gf = 0; gf < NUM_FC; gf++) begin : g_fc
      localparam int FLOW = gv * NUM_FC + gf;

      logic [RTN_W-1:0] inc;
      logic [RTN_W-1:0] dec;

      // steer the free strobe and the return to this flow
      assign inc = (free.valid && int'(free.vc) == gv && int'(free.fc) == gf) ?
                   free.value : '0;
      assign dec = (dec_flow == FLOW_W'(FLOW)) ? dec_val : '0;

      always_ff @(posedge clk_gated or negedge rst_b) begin
        if (!rst_b) begin
          cnt_q[FLOW] <= '0;
        end else if (load) begin
          cnt_q[FLOW] <= CNT_W'(INIT_CRD[CHAN][gv][gf]);
        end else if (count_en) begin
          cnt_q[FLOW] <= cnt_q[FLOW] + CNT_W'(inc) - CNT_W'(dec);  // free plus count minus rtn
        end
      end

      assign reqs[FLOW] = |cnt_q[FLOW];  // anything left to give back

      // the channel never returns more than it holds
      a_no_underflow : assert property (@(posedge clk_gated) disable iff (!rst_b)
        (count_en && dec_flow == FLOW_W'(FLOW)) |-> (CNT_W'(dec_val) <= cnt_q[FLOW]));
    end
  end

  assign cnts = cnt_q;

endmodule

/* hdl/crd_rr_arbiter.sv */
// round robin flow arbiter
`timescale 1ns/1ps

module crd_rr_arbiter (
  input  logic                              clk_gated,
  input  logic                              rst_b,
  input  logic [sfi_crd_pkg::NUM_FLOWS-1:0] reqs,
  input  logic                              update,    // winner served in full
  output logic                              winner_v,
  output logic [sfi_crd_pkg::FLOW_W-1:0]    winner
);

  import sfi_crd_pkg::*;

  logic [FLOW_W-1:0] ptr_q;  // first flow to look at

  // lowest offset from the pointer wins
  always_comb begin
    int idx;
    winner_v = 1'b0;
    winner   = '0;
    for (int i = NUM_FLOWS - 1; i >= 0; i--) begin
      idx = int'(ptr_q) + i;
      if (idx >= NUM_FLOWS) begin
        idx = idx - NUM_FLOWS;  // wrap
      end
      if (reqs[idx]) begin
        winner_v = 1'b1;
        winner   = FLOW_W'(idx);
      end
    end
  end

  always_ff @(posedge clk_gated or negedge rst_b) begin
    if (!rst_b) begin
      ptr_q <= '0;  // flow 0 first
    end else if (update) begin
      ptr_q <= (winner == FLOW_W'(NUM_FLOWS - 1)) ? '0 : winner + 1'b1;  // one past winner
    end
  end

  // pointer only moves past a flow that was actually granted
  a_update_granted : assert property (@(posedge clk_gated) disable iff (!rst_b)
    update |-> winner_v);

endmodule

/* hdl/crd_rtn_channel.sv */
// credit return channel
`timescale 1ns/1ps

module crd_rtn_channel #(
  parameter int CHAN = sfi_crd_pkg::CHAN_HDR
) (
  input  logic                                                  clk_gated,
  input  logic                                                  rst_b,
  input  logic                                                  load,
  input  logic                                                  count_en,
  input  logic                                                  hold,
  input  logic [sfi_crd_pkg::VC_MAP_W*sfi_crd_pkg::NUM_VCS-1:0] vc_map,
  input  sfi_crd_pkg::crd_free_t                                free,
  output sfi_crd_pkg::crd_rtn_t                                 rtn,
  output logic                                                  empty
);

  import sfi_crd_pkg::*;

  localparam logic [RTN_W-1:0] RTN_CAP = RTN_W'(RTN_MAX[CHAN]);

  logic [NUM_FLOWS-1:0]            reqs;
  logic [NUM_FLOWS-1:0][CNT_W-1:0] cnts;
  logic [NUM_FLOWS-1:0]            inf_mask;  // flows advertised as infinite
  logic                            winner_v;
  logic [FLOW_W-1:0]               winner;
  logic [VC_W-1:0]                 win_vc;
  fc_id_t                          win_fc;
  logic [CNT_W-1:0]                win_cnt;
  logic [RTN_W-1:0]                dec_val;
  logic                            update;

  for (genvar gf = 0; gf < NUM_FLOWS; gf++) begin : g_inf
    assign inf_mask[gf] = INF_CRD[CHAN][gf / NUM_FC][gf % NUM_FC];
  end

  crd_rtn_counters #(.CHAN(CHAN)) u_counters (
    .clk_gated (clk_gated),
    .rst_b     (rst_b),
    .load      (load),
    .count_en  (count_en),
    .free      (free),
    .dec_flow  (winner),
    .dec_val   (dec_val),
    .reqs      (reqs),
    .cnts      (cnts)
  );

  crd_rr_arbiter u_arb (
    .clk_gated (clk_gated),
    .rst_b     (rst_b),
    .reqs      (reqs),
    .update    (update),
    .winner_v  (winner_v),
    .winner    (winner)
  );

  // --------------------
  // winner to vc/fc
  // --------------------
  always_comb begin
    win_vc = '0;
    win_fc = FC_P;
    for (int v = 0; v < NUM_VCS; v++) begin
      for (int f = 0; f < NUM_FC; f++) begin
        if (int'(winner) == v * NUM_FC + f) begin
          win_vc = VC_W'(v);
          win_fc = fc_id_t'(f);
        end
      end
    end
  end

  assign win_cnt = cnts[winner];

  // full return moves the pointer on, a capped one keeps the same flow
  always_comb begin
    rtn     = '0;
    dec_val = '0;
    update  = 1'b0;
    if (winner_v && !hold) begin
      rtn.valid = 1'b1;
      rtn.vc_id = vc_map[int'(win_vc) * VC_MAP_W +: LINK_VC_W];  // local to link vc
      rtn.fc    = win_fc;
      if (win_cnt <= CNT_W'(RTN_CAP)) begin
        dec_val   = win_cnt[RTN_W-1:0];
        rtn.value = inf_mask[winner] ? '0 : win_cnt[RTN_W-1:0];  // infinite goes out as 0
        update    = 1'b1;
      end else begin
        dec_val   = RTN_CAP;
        rtn.value = RTN_CAP;
      end
    end
  end

  assign empty = ~|reqs;

  // only an infinite advertisement may carry a zero value
  a_rtn_nonzero : assert property (@(posedge clk_gated) disable iff (!rst_b)
    (rtn.valid && !inf_mask[winner]) |-> (rtn.value != '0));

endmodule

/* hdl/sfi_rx_crd.sv */
// rx credit return manager
`timescale 1ns/1ps

module sfi_rx_crd (
  input  logic                                                  clk_gated,
  input  logic                                                  rst_b,
  input  logic                                                  connected,
  input  logic                                                  disconnected,
  input  logic [sfi_crd_pkg::VC_MAP_W*sfi_crd_pkg::NUM_VCS-1:0] vc_map,
  input  logic                                                  force_blocks,
  input  logic                                                  go_idle_ack,
  input  logic                                                  hdr_block,
  input  logic                                                  data_block,
  input  sfi_crd_pkg::crd_free_t                                hdr_free,
  input  sfi_crd_pkg::crd_free_t                                data_free,
  output sfi_crd_pkg::crd_rtn_t                                 hdr_rtn,
  output sfi_crd_pkg::crd_rtn_t                                 data_rtn,
  output logic                                                  crd_idle
);

  import sfi_crd_pkg::*;

  logic load;
  logic count_en;
  logic hdr_hold;
  logic data_hold;
  logic hdr_empty;   // no header credits pending
  logic data_empty;  // no data credits pending

  crd_link_ctrl u_link_ctrl (
    .clk_gated    (clk_gated),
    .rst_b        (rst_b),
    .connected    (connected),
    .disconnected (disconnected),
    .force_blocks (force_blocks),
    .go_idle_ack  (go_idle_ack),
    .hdr_block    (hdr_block),
    .data_block   (data_block),
    .hdr_empty    (hdr_empty),
    .data_empty   (data_empty),
    .load         (load),
    .count_en     (count_en),
    .hdr_hold     (hdr_hold),
    .data_hold    (data_hold),
    .crd_idle     (crd_idle)
  );

  // --------------------
  // header and data channels
  // --------------------
  crd_rtn_channel #(.CHAN(CHAN_HDR)) u_hdr_chan (
    .clk_gated (clk_gated),
    .rst_b     (rst_b),
    .load      (load),
    .count_en  (count_en),
    .hold      (hdr_hold),
    .vc_map    (vc_map),
    .free      (hdr_free),
    .rtn       (hdr_rtn),
    .empty     (hdr_empty)
  );

  crd_rtn_channel #(.CHAN(CHAN_DATA)) u_data_chan (
    .clk_gated (clk_gated),
    .rst_b     (rst_b),
    .load      (load),
    .count_en  (count_en),
    .hold      (data_hold),
    .vc_map    (vc_map),
    .free      (data_free),
    .rtn       (data_rtn),
    .empty     (data_empty)
  );

endmodule

/* bench/tb_sfi_rx_crd.sv */
// rx credit return testbench
`timescale 1ns/1ps

module tb_sfi_rx_crd;

  import sfi_crd_pkg::*;

  localparam int HALF_PERIOD  = 50;   // 100 ns clock
  localparam int RST_CYCLES   = 3;
  localparam int SLACK_CYCLES = 20;   // watchdog margin
  localparam int NUM_FIELDS   = 24;   // numeric columns per golden line

  // one golden line, stimulus then expected outputs
  typedef struct packed {
    logic                          conn;
    logic                          disc;
    logic [VC_MAP_W*NUM_VCS-1:0]   vc_map;
    logic                          fblk;
    logic                          gidle;
    logic                          hblk;
    logic                          dblk;
    crd_free_t                     hdr_free;
    crd_free_t                     data_free;
    crd_rtn_t                      exp_hdr;
    crd_rtn_t                      exp_data;
    logic                          exp_idle;
  } vec_t;

  logic                        clk_gated;
  logic                        rst_b;
  logic                        connected;
  logic                        disconnected;
  logic [VC_MAP_W*NUM_VCS-1:0] vc_map;
  logic                        force_blocks;
  logic                        go_idle_ack;
  logic                        hdr_block;
  logic                        data_block;
  crd_free_t                   hdr_free;
  crd_free_t                   data_free;
  crd_rtn_t                    hdr_rtn;
  crd_rtn_t                    data_rtn;
  logic                        crd_idle;

  vec_t  vecs [$];
  string names [$];
  bit    loaded = 1'b0;  // watchdog starts once the file is in

  sfi_rx_crd sfi_rx_crd_inst (
    .clk_gated    (clk_gated),
    .rst_b        (rst_b),
    .connected    (connected),
    .disconnected (disconnected),
    .vc_map       (vc_map),
    .force_blocks (force_blocks),
    .go_idle_ack  (go_idle_ack),
    .hdr_block    (hdr_block),
    .data_block   (data_block),
    .hdr_free     (hdr_free),
    .data_free    (data_free),
    .hdr_rtn      (hdr_rtn),
    .data_rtn     (data_rtn),
    .crd_idle     (crd_idle)
  );

  always #HALF_PERIOD clk_gated = ~clk_gated;

  // --------------------
  // helpers
  // --------------------
  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s %s expected %h actual %h", test, field, expected, actual);
      stop_run("first mismatch ends the run");
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    int    fld [NUM_FIELDS];
    string line;
    string name;
    vec_t  v;
    fd = $fopen("bench/crd_golden.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open the golden file bench/crd_golden.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments and blanks
          n = $sscanf(line,
                      "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      name, fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                      fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                      fld[15], fld[16], fld[17], fld[18], fld[19], fld[20], fld[21],
                      fld[22], fld[23]);
          if (n != NUM_FIELDS + 1) begin
            stop_run({"badly formed golden line: ", line});
          end
          v.conn            = fld[0][0];
          v.disc            = fld[1][0];
          v.vc_map          = fld[2][VC_MAP_W*NUM_VCS-1:0];
          v.fblk            = fld[3][0];
          v.gidle           = fld[4][0];
          v.hblk            = fld[5][0];
          v.dblk            = fld[6][0];
          v.hdr_free.valid  = fld[7][0];
          v.hdr_free.vc     = fld[8][VC_W-1:0];
          v.hdr_free.fc     = fc_id_t'(fld[9][1:0]);
          v.hdr_free.value  = fld[10][RTN_W-1:0];
          v.data_free.valid = fld[11][0];
          v.data_free.vc    = fld[12][VC_W-1:0];
          v.data_free.fc    = fc_id_t'(fld[13][1:0]);
          v.data_free.value = fld[14][RTN_W-1:0];
          v.exp_hdr.valid   = fld[15][0];
          v.exp_hdr.vc_id   = fld[16][LINK_VC_W-1:0];  // link side id
          v.exp_hdr.fc      = fc_id_t'(fld[17][1:0]);
          v.exp_hdr.value   = fld[18][RTN_W-1:0];
          v.exp_data.valid  = fld[19][0];
          v.exp_data.vc_id  = fld[20][LINK_VC_W-1:0];
          v.exp_data.fc     = fc_id_t'(fld[21][1:0]);
          v.exp_data.value  = fld[22][RTN_W-1:0];
          v.exp_idle        = fld[23][0];
          names.push_back(name);
          vecs.push_back(v);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_vector(input vec_t v);
    connected    = v.conn;
    disconnected = v.disc;
    vc_map       = v.vc_map;
    force_blocks = v.fblk;
    go_idle_ack  = v.gidle;
    hdr_block    = v.hblk;
    data_block   = v.dblk;
    hdr_free     = v.hdr_free;   // one cycle strobe
    data_free    = v.data_free;
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int idx;
    clk_gated    = 1'b0;
    rst_b        = 1'b0;
    connected    = 1'b0;
    disconnected = 1'b0;
    vc_map       = '0;
    force_blocks = 1'b0;
    go_idle_ack  = 1'b0;
    hdr_block    = 1'b0;
    data_block   = 1'b0;
    hdr_free     = '0;
    data_free    = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(negedge clk_gated);
    rst_b = 1'b1;
    for (idx = 0; idx < vecs.size(); idx++) begin
      @(negedge clk_gated);
      apply_vector(vecs[idx]);
      #(HALF_PERIOD / 2);  // outputs settled, rising edge still ahead
      check_value(names[idx], "hdr_rtn", {22'b0, vecs[idx].exp_hdr}, {22'b0, hdr_rtn});
      check_value(names[idx], "data_rtn", {22'b0, vecs[idx].exp_data}, {22'b0, data_rtn});
      check_value(names[idx], "crd_idle", {31'b0, vecs[idx].exp_idle}, {31'b0, crd_idle});
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // --------------------
  // watchdog
  // --------------------
  initial begin
    longint limit_ns;
    wait (loaded);
    limit_ns = longint'(RST_CYCLES + vecs.size() + SLACK_CYCLES) * 2 * HALF_PERIOD;
    #(limit_ns);
    stop_run("timeout: the golden vectors did not finish in time");
  end

endmodule

/* sfi_rx_crd.f */
hdl/sfi_crd_pkg.sv
hdl/crd_link_ctrl.sv
hdl/crd_rtn_counters.sv
hdl/crd_rr_arbiter.sv
hdl/crd_rtn_channel.sv
hdl/sfi_rx_crd.sv
bench/tb_sfi_rx_crd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the rx credit return testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_sfi_rx_crd \
  -f sfi_rx_crd.f \
  -o tb_sfi_rx_crd
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/tb_sfi_rx_crd
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi
exit 0

/* bench/crd_golden.txt */
# name conn disc vc_map force_blocks go_idle_ack hdr_block data_block, hdr_free v vc fc val,
# data_free v vc fc val, expect hdr_rtn v vc_id fc val, data_rtn v vc_id fc val, crd_idle (hex)
reset_idle      0 0 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0
connect_load    1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0
chunk_first     1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 0 f  1 2 0 7  0
hold_hdr_block  1 0 52 0 0 1 0  0 0 0 0  0 0 0 0  0 0 0 0  1 2 0 2  0
hold_force      1 0 52 1 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0
hold_go_idle    1 0 52 0 1 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0
resume_chunk    1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 0 5  1 2 1 1  0
rr_np           1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 1 2  1 2 2 0  0
inf_cpl         1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 2 0  0 0 0 0  0
rr_vc1          1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 5 0 3  0 0 0 0  0
idle_high       1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  1
free_strobe     1 0 52 0 0 0 0  1 1 1 4  0 0 0 0  0 0 0 0  0 0 0 0  1
free_return     1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 5 1 4  0 0 0 0  0
free_once       1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  1
disconnect      0 1 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  1
disc_idle_low   0 0 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0
reconnect_load  1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0
reinit_first    1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 0 f  1 2 0 7  0
free_same_cycle 1 0 52 0 0 0 0  1 0 0 3  0 0 0 0  1 2 0 5  1 2 0 2  0
rr_np_again     1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 1 2  1 2 1 1  0
inf_again       1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 2 0  1 2 2 0  0
rr_vc1_again    1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 5 0 3  0 0 0 0  0
free_wrap       1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  1 2 0 3  0 0 0 0  0
idle_final      1 0 52 0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  0 0 0 0  1
